// ==== project.f ====
+incdir+hdl
hdl/simt_pkg.sv
hdl/skid_buffer.sv
hdl/instr_decode.sv
hdl/operand_collector.sv
hdl/alu_execute.sv
hdl/result_unit.sv
hdl/simt_core.sv
testbench/tb_simt_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the SIMT core testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_simt_core \
        -f project.f -o sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== testbench/tb_simt_core.sv ====
/* Testbench for the SIMT core slice
   Issues one instruction at a time against a per-warp register model */
`timescale 1ns/10ps
`include "simt_defs.svh"

module tb_simt_core;
    localparam int WAIT_LIMIT = 200;

    logic                       clk;
    logic                       reset;
    logic                       instr_valid;
    logic                       instr_ready;
    logic [31:0]                instr;
    logic [`SIMT_WARP_BITS-1:0] instr_warp;
    logic [`SIMT_THREADS-1:0]   instr_tmask;
    logic                       result_valid;
    logic                       result_ready;
    logic [`SIMT_WARP_BITS-1:0] result_warp;
    logic [`SIMT_REG_BITS-1:0]  result_rd;
    logic [`SIMT_THREADS-1:0]   result_tmask;
    simt_pkg::thread_data_t     result_data;

    logic [`SIMT_XLEN-1:0] ref_regs [`SIMT_WARPS][`SIMT_NREGS][`SIMT_THREADS];
    simt_pkg::thread_data_t     exp_data;
    logic [`SIMT_WARP_BITS-1:0] exp_warp;
    logic [`SIMT_REG_BITS-1:0]  exp_rd;
    logic [`SIMT_THREADS-1:0]   exp_tmask;
    logic                       pending;
    string                      test_name;
    int                         errors;
    int                         timeouts;

    simt_core dut (
        .clk (clk), .reset (reset),
        .instr_valid (instr_valid), .instr_ready (instr_ready), .instr (instr),
        .instr_warp (instr_warp), .instr_tmask (instr_tmask),
        .result_valid (result_valid), .result_ready (result_ready),
        .result_warp (result_warp), .result_rd (result_rd),
        .result_tmask (result_tmask), .result_data (result_data)
    );

    always #4 clk = ~clk;

    function automatic logic [`SIMT_XLEN-1:0] lane_expect(input logic [3:0] op,
        input logic [`SIMT_XLEN-1:0] a, input logic [`SIMT_XLEN-1:0] b,
        input logic [`SIMT_XLEN-1:0] c, input logic [7:0] imm);
        case (op)
            simt_pkg::SUB: return a - b;
            simt_pkg::AND: return a & b;
            simt_pkg::OR:  return a | b;
            simt_pkg::XOR: return a ^ b;
            simt_pkg::MAD: return a * b + c;
            simt_pkg::LI:  return {24'd0, imm};
            default:       return a + b;
        endcase
    endfunction

    // Waits for the core to take the instruction, then drops valid
    task automatic send_instr(input int op, input int warp, input int rd, input int rs1,
        input int rs2, input int rs3, input int imm, input int mask);
        int waited;
        exp_warp  = 1'(warp);
        exp_rd    = 5'(rd);
        exp_tmask = 4'(mask);
        for (int t = 0; t < `SIMT_THREADS; t++) begin
            exp_data[t] = mask[t] ? lane_expect(4'(op), ref_regs[warp][rs1][t],
                ref_regs[warp][rs2][t], ref_regs[warp][rs3][t], 8'(imm)) : '0;
        end
        pending     = 1'b1;
        instr       = {8'(imm), 5'(rs3), 5'(rs2), 5'(rs1), 5'(rd), 4'(op)};
        instr_warp  = 1'(warp);
        instr_tmask = 4'(mask);
        instr_valid = 1'b1;
        waited = 0;
        while (!instr_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!instr_ready) begin
            timeouts++;
            $display("Timeout: the core never accepted the instruction in %s", test_name);
        end else begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    // Stalls result_ready at random until the result leaves the core
    task automatic collect_result();
        int   waited;
        logic got;
        got    = 1'b0;
        waited = 0;
        while (!got && waited < WAIT_LIMIT) begin
            result_ready = ($urandom % 3) != 0;
            if (result_valid && result_ready) begin
                got = 1'b1;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        if (!got) begin
            timeouts++;
            $display("Timeout: no result came out of the core in %s", test_name);
        end else begin
            @(negedge clk);
            result_ready = 1'b0;
            pending      = 1'b0;
            for (int t = 0; t < `SIMT_THREADS; t++) begin
                if (exp_rd != '0 && exp_tmask[t]) begin
                    ref_regs[exp_warp][exp_rd][t] = exp_data[t];
                end
            end
        end
    endtask

    task automatic run_instr(input int op, input int warp, input int rd, input int rs1,
        input int rs2, input int rs3, input int imm, input int mask);
        if (timeouts == 0) begin
            send_instr(op, warp, rd, rs1, rs2, rs3, imm, mask);
        end
        if (timeouts == 0) begin
            collect_result();
        end
    endtask

    assert property (@(posedge clk) disable iff (reset)
        result_valid && result_ready && pending |-> result_data == exp_data)
    else begin
        errors++;
        $display("** Error %s: data expected %h, actual %h",
                 test_name, exp_data, $sampled(result_data));
    end

    assert property (@(posedge clk) disable iff (reset)
        result_valid && result_ready && pending |->
        {result_warp, result_rd, result_tmask} == {exp_warp, exp_rd, exp_tmask})
    else begin
        errors++;
        $display("** Error %s: warp/rd/tmask expected %h, actual %h", test_name,
                 {exp_warp, exp_rd, exp_tmask},
                 $sampled({result_warp, result_rd, result_tmask}));
    end

    // A duplicated or spurious result shows up while nothing is outstanding
    assert property (@(posedge clk) disable iff (reset)
        result_valid |-> pending)
    else begin
        errors++;
        $display("A result appeared with no instruction outstanding in %s", test_name);
    end

    // Back-pressure must freeze the result and its payload
    assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(result_data) &&
        $stable(result_rd) && $stable(result_warp) && $stable(result_tmask))
    else begin
        errors++;
        $display("The result changed or vanished while stalled in %s", test_name);
    end

    initial begin
        int op;
        clk          = 1'b0;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        instr_warp   = '0;
        instr_tmask  = '0;
        result_ready = 1'b0;
        pending      = 1'b0;
        errors       = 0;
        timeouts     = 0;
        test_name    = "reset";
        void'($urandom(32'h325b_65a0));
        for (int w = 0; w < `SIMT_WARPS; w++) begin
            for (int r = 0; r < `SIMT_NREGS; r++) begin
                for (int t = 0; t < `SIMT_THREADS; t++) begin
                    ref_regs[w][r][t] = '0;
                end
            end
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // Every register the later tests read gets a known value in all lanes
        test_name = "init_regs";
        for (int w = 0; w < `SIMT_WARPS; w++) begin
            for (int r = 1; r < 8; r++) begin
                run_instr(simt_pkg::LI, w, r, 0, 0, 0, $urandom_range(255, 0), 15);
            end
        end

        test_name = "li_mask";
        run_instr(simt_pkg::LI, 0, 3, 4, 5, 6, $urandom_range(255, 0), 4'b0101);
        run_instr(simt_pkg::ADD, 0, 8, 3, 0, 0, 0, 15);

        test_name = "alu_random";
        repeat (40) begin
            op = ($urandom % 8 == 0) ? 12 : $urandom_range(4, 0);
            run_instr(op, $urandom_range(1, 0), $urandom_range(7, 1), $urandom_range(7, 0),
                      $urandom_range(7, 0), 0, 0, $urandom_range(15, 1));
        end

        test_name = "mad";
        run_instr(simt_pkg::MAD, 0, 6, 1, 2, 3, 0, 15);
        run_instr(simt_pkg::LI, 0, 5, 0, 0, 0, $urandom_range(255, 0), 15);
        run_instr(simt_pkg::MAD, 0, 7, 5, 2, 5, 0, 15);
        run_instr(simt_pkg::MAD, 0, 4, 7, 7, 1, 0, 4'b0110);

        // Warp 1 moves its cache off r4 so the final read comes from the banks
        test_name = "warp_split";
        run_instr(simt_pkg::LI, 1, 4, 0, 0, 0, $urandom_range(255, 0), 15);
        run_instr(simt_pkg::LI, 1, 5, 0, 0, 0, $urandom_range(255, 0), 15);
        run_instr(simt_pkg::LI, 0, 4, 0, 0, 0, $urandom_range(255, 0), 15);
        run_instr(simt_pkg::ADD, 1, 9, 4, 0, 0, 0, 15);

        test_name = "zero_reg";
        run_instr(simt_pkg::ADD, 0, 0, 1, 2, 0, 0, 15);
        run_instr(simt_pkg::ADD, 0, 10, 0, 0, 0, 0, 15);
        run_instr(simt_pkg::OR, 0, 11, 0, 1, 0, 0, 15);

        @(negedge clk);
        $display("Errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hdl/simt_core.sv ====
/* SIMT core operand and execution slice
   Decode, operand collect, execute and result stages in a row */
`timescale 1ns/10ps
`include "simt_defs.svh"

module simt_core (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instr_valid,
    output logic                       instr_ready,
    input  logic [31:0]                instr,
    input  logic [`SIMT_WARP_BITS-1:0] instr_warp,
    input  logic [`SIMT_THREADS-1:0]   instr_tmask,
    output logic                       result_valid,
    input  logic                       result_ready,
    output logic [`SIMT_WARP_BITS-1:0] result_warp,
    output logic [`SIMT_REG_BITS-1:0]  result_rd,
    output logic [`SIMT_THREADS-1:0]   result_tmask,
    output simt_pkg::thread_data_t     result_data
);
    logic                       dec_valid, dec_ready;
    simt_pkg::alu_op_e          dec_op;
    logic [`SIMT_REG_BITS-1:0]  dec_rd, dec_rs1, dec_rs2, dec_rs3;
    logic [`SIMT_IMM_BITS-1:0]  dec_imm;
    logic [`SIMT_WARP_BITS-1:0] dec_warp;
    logic [`SIMT_THREADS-1:0]   dec_tmask;

    logic                       opd_valid, opd_ready;
    simt_pkg::alu_op_e          opd_op;
    logic [`SIMT_REG_BITS-1:0]  opd_rd;
    logic [`SIMT_IMM_BITS-1:0]  opd_imm;
    logic [`SIMT_WARP_BITS-1:0] opd_warp;
    logic [`SIMT_THREADS-1:0]   opd_tmask;
    simt_pkg::thread_data_t     opd_rs1_data, opd_rs2_data, opd_rs3_data;

    logic                       exe_valid, exe_ready;
    logic [`SIMT_REG_BITS-1:0]  exe_rd;
    logic [`SIMT_WARP_BITS-1:0] exe_warp;
    logic [`SIMT_THREADS-1:0]   exe_tmask;
    simt_pkg::thread_data_t     exe_data;

    logic                       wb_valid;
    logic [`SIMT_WARP_BITS-1:0] wb_warp;
    logic [`SIMT_REG_BITS-1:0]  wb_rd;
    logic [`SIMT_THREADS-1:0]   wb_tmask;
    simt_pkg::thread_data_t     wb_data;

    instr_decode u_decode (
        .clk (clk), .reset (reset),
        .instr_valid (instr_valid), .instr_ready (instr_ready), .instr (instr),
        .instr_warp (instr_warp), .instr_tmask (instr_tmask),
        .dec_valid (dec_valid), .dec_ready (dec_ready), .dec_op (dec_op),
        .dec_rd (dec_rd), .dec_rs1 (dec_rs1), .dec_rs2 (dec_rs2), .dec_rs3 (dec_rs3),
        .dec_imm (dec_imm), .dec_warp (dec_warp), .dec_tmask (dec_tmask)
    );

    operand_collector u_collector (
        .clk (clk), .reset (reset),
        .dec_valid (dec_valid), .dec_ready (dec_ready), .dec_op (dec_op),
        .dec_rd (dec_rd), .dec_rs1 (dec_rs1), .dec_rs2 (dec_rs2), .dec_rs3 (dec_rs3),
        .dec_imm (dec_imm), .dec_warp (dec_warp), .dec_tmask (dec_tmask),
        .wb_valid (wb_valid), .wb_warp (wb_warp), .wb_rd (wb_rd),
        .wb_tmask (wb_tmask), .wb_data (wb_data),
        .opd_valid (opd_valid), .opd_ready (opd_ready), .opd_op (opd_op),
        .opd_rd (opd_rd), .opd_imm (opd_imm), .opd_warp (opd_warp), .opd_tmask (opd_tmask),
        .opd_rs1_data (opd_rs1_data), .opd_rs2_data (opd_rs2_data),
        .opd_rs3_data (opd_rs3_data)
    );

    alu_execute u_execute (
        .clk (clk), .reset (reset),
        .opd_valid (opd_valid), .opd_ready (opd_ready), .opd_op (opd_op),
        .opd_rd (opd_rd), .opd_imm (opd_imm), .opd_warp (opd_warp), .opd_tmask (opd_tmask),
        .opd_rs1_data (opd_rs1_data), .opd_rs2_data (opd_rs2_data),
        .opd_rs3_data (opd_rs3_data),
        .exe_valid (exe_valid), .exe_ready (exe_ready), .exe_rd (exe_rd),
        .exe_warp (exe_warp), .exe_tmask (exe_tmask), .exe_data (exe_data)
    );

    result_unit u_result (
        .clk (clk), .reset (reset),
        .exe_valid (exe_valid), .exe_ready (exe_ready), .exe_rd (exe_rd),
        .exe_warp (exe_warp), .exe_tmask (exe_tmask), .exe_data (exe_data),
        .result_valid (result_valid), .result_ready (result_ready),
        .result_warp (result_warp), .result_rd (result_rd),
        .result_tmask (result_tmask), .result_data (result_data),
        .wb_valid (wb_valid), .wb_warp (wb_warp), .wb_rd (wb_rd),
        .wb_tmask (wb_tmask), .wb_data (wb_data)
    );

endmodule

// ==== hdl/result_unit.sv ====
/* Result stage
   Holds one result at the outputs and writes it back when it leaves */
`timescale 1ns/10ps
`include "simt_defs.svh"

module result_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       exe_valid,
    output logic                       exe_ready,
    input  logic [`SIMT_REG_BITS-1:0]  exe_rd,
    input  logic [`SIMT_WARP_BITS-1:0] exe_warp,
    input  logic [`SIMT_THREADS-1:0]   exe_tmask,
    input  simt_pkg::thread_data_t     exe_data,
    output logic                       result_valid,
    input  logic                       result_ready,
    output logic [`SIMT_WARP_BITS-1:0] result_warp,
    output logic [`SIMT_REG_BITS-1:0]  result_rd,
    output logic [`SIMT_THREADS-1:0]   result_tmask,
    output simt_pkg::thread_data_t     result_data,
    output logic                       wb_valid,
    output logic [`SIMT_WARP_BITS-1:0] wb_warp,
    output logic [`SIMT_REG_BITS-1:0]  wb_rd,
    output logic [`SIMT_THREADS-1:0]   wb_tmask,
    output simt_pkg::thread_data_t     wb_data
);
    assign exe_ready = !result_valid || result_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (exe_ready) begin
            result_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid && exe_ready) begin
            result_warp  <= exe_warp;
            result_rd    <= exe_rd;
            result_tmask <= exe_tmask;
            result_data  <= exe_data;
        end
    end

    // Register 0 is never written, but its result is still reported
    assign wb_valid = result_valid && result_ready && (result_rd != '0);
    assign wb_warp  = result_warp;
    assign wb_rd    = result_rd;
    assign wb_tmask = result_tmask;
    assign wb_data  = result_data;

    // Each result is written back once, never again on the next cycle
    assert property (@(posedge clk) disable iff (reset)
        wb_valid |=> $past(result_valid && result_ready) &&
                     (!wb_valid || $past(exe_valid && exe_ready)));

endmodule

// ==== hdl/alu_execute.sv ====
/* Execute stage
   One ALU per thread, result registered with its destination */
`timescale 1ns/10ps
`include "simt_defs.svh"

module alu_execute (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       opd_valid,
    output logic                       opd_ready,
    input  simt_pkg::alu_op_e          opd_op,
    input  logic [`SIMT_REG_BITS-1:0]  opd_rd,
    input  logic [`SIMT_IMM_BITS-1:0]  opd_imm,
    input  logic [`SIMT_WARP_BITS-1:0] opd_warp,
    input  logic [`SIMT_THREADS-1:0]   opd_tmask,
    input  simt_pkg::thread_data_t     opd_rs1_data,
    input  simt_pkg::thread_data_t     opd_rs2_data,
    input  simt_pkg::thread_data_t     opd_rs3_data,
    output logic                       exe_valid,
    input  logic                       exe_ready,
    output logic [`SIMT_REG_BITS-1:0]  exe_rd,
    output logic [`SIMT_WARP_BITS-1:0] exe_warp,
    output logic [`SIMT_THREADS-1:0]   exe_tmask,
    output simt_pkg::thread_data_t     exe_data
);
    function automatic logic [`SIMT_XLEN-1:0] lane_op(
        input simt_pkg::alu_op_e          op,
        input logic [`SIMT_XLEN-1:0]      a,
        input logic [`SIMT_XLEN-1:0]      b,
        input logic [`SIMT_XLEN-1:0]      c,
        input logic [`SIMT_IMM_BITS-1:0]  imm
    );
        case (op)
            simt_pkg::SUB: return a - b;
            simt_pkg::AND: return a & b;
            simt_pkg::OR:  return a | b;
            simt_pkg::XOR: return a ^ b;
            simt_pkg::MAD: return a * b + c;
            simt_pkg::LI:  return {{(`SIMT_XLEN-`SIMT_IMM_BITS){1'b0}}, imm};
            default:       return a + b;
        endcase
    endfunction

    assign opd_ready = !exe_valid || exe_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else if (opd_ready) begin
            exe_valid <= opd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (opd_valid && opd_ready) begin
            exe_rd    <= opd_rd;
            exe_warp  <= opd_warp;
            exe_tmask <= opd_tmask;
            for (int t = 0; t < `SIMT_THREADS; t++) begin
                exe_data[t] <= opd_tmask[t] ? lane_op(opd_op, opd_rs1_data[t],
                    opd_rs2_data[t], opd_rs3_data[t], opd_imm) : '0;
            end
        end
    end

endmodule

// ==== hdl/operand_collector.sv ====
/* Operand collector
   Banked per-warp register file, last-write cache per warp and the
   source fetch FSM feeding a staging buffer and an output buffer */
`timescale 1ns/10ps
`include "simt_defs.svh"

module operand_collector (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       dec_valid,
    output logic                       dec_ready,
    input  simt_pkg::alu_op_e          dec_op,
    input  logic [`SIMT_REG_BITS-1:0]  dec_rd,
    input  logic [`SIMT_REG_BITS-1:0]  dec_rs1,
    input  logic [`SIMT_REG_BITS-1:0]  dec_rs2,
    input  logic [`SIMT_REG_BITS-1:0]  dec_rs3,
    input  logic [`SIMT_IMM_BITS-1:0]  dec_imm,
    input  logic [`SIMT_WARP_BITS-1:0] dec_warp,
    input  logic [`SIMT_THREADS-1:0]   dec_tmask,
    input  logic                       wb_valid,
    input  logic [`SIMT_WARP_BITS-1:0] wb_warp,
    input  logic [`SIMT_REG_BITS-1:0]  wb_rd,
    input  logic [`SIMT_THREADS-1:0]   wb_tmask,
    input  simt_pkg::thread_data_t     wb_data,
    output logic                       opd_valid,
    input  logic                       opd_ready,
    output simt_pkg::alu_op_e          opd_op,
    output logic [`SIMT_REG_BITS-1:0]  opd_rd,
    output logic [`SIMT_IMM_BITS-1:0]  opd_imm,
    output logic [`SIMT_WARP_BITS-1:0] opd_warp,
    output logic [`SIMT_THREADS-1:0]   opd_tmask,
    output simt_pkg::thread_data_t     opd_rs1_data,
    output simt_pkg::thread_data_t     opd_rs2_data,
    output simt_pkg::thread_data_t     opd_rs3_data
);
    typedef struct packed {
        simt_pkg::alu_op_e          op;
        logic [`SIMT_REG_BITS-1:0]  rd;
        logic [`SIMT_IMM_BITS-1:0]  imm;
        logic [`SIMT_WARP_BITS-1:0] warp;
        logic [`SIMT_THREADS-1:0]   tmask;
    } stage_t;

    typedef struct packed {
        stage_t                 ctl;
        simt_pkg::thread_data_t rs1;
        simt_pkg::thread_data_t rs2;
        simt_pkg::thread_data_t rs3;
    } opd_t;

    typedef enum logic [1:0] {IDLE, FETCH1, FETCH2, FETCH3} state_e;

    state_e                      state;
    logic [`SIMT_REG_BITS-1:0]   rd_rid;
    logic [`SIMT_WARP_BITS-1:0]  rd_warp;
    logic [`SIMT_REG_BITS-1:0]   rs2_id;
    logic [`SIMT_REG_BITS-1:0]   rs3_id;
    logic                        rs2_done;
    logic                        rs3_done;
    logic                        data_ready;
    simt_pkg::thread_data_t      rd_data;
    simt_pkg::thread_data_t      rs1_val;
    simt_pkg::thread_data_t      rs2_val;
    simt_pkg::thread_data_t      rs3_val;

    logic [`SIMT_WARPS-1:0]      cache_valid;
    logic [`SIMT_REG_BITS-1:0]   cache_reg [`SIMT_WARPS];
    logic [`SIMT_THREADS-1:0]    cache_tmask [`SIMT_WARPS];
    simt_pkg::thread_data_t      cache_data [`SIMT_WARPS];

    logic   cache_cover;
    logic   rs1_zero, rs2_zero, rs3_zero;
    logic   rs1_free, rs2_free, rs3_free;
    logic   dec_fire, stage_fire;
    logic   stage_in_ready, stage_valid, out_in_ready;
    stage_t stage_out;
    opd_t   opd_out;

    // A hit needs the cached mask to cover every active thread
    assign cache_cover = cache_valid[dec_warp] &&
                         ((dec_tmask & cache_tmask[dec_warp]) == dec_tmask);
    assign rs1_zero = (dec_rs1 == '0);
    assign rs2_zero = (dec_rs2 == '0);
    assign rs3_zero = (dec_rs3 == '0);
    assign rs1_free = rs1_zero || (cache_cover && dec_rs1 == cache_reg[dec_warp]);
    assign rs2_free = rs2_zero || (cache_cover && dec_rs2 == cache_reg[dec_warp]);
    assign rs3_free = rs3_zero || (cache_cover && dec_rs3 == cache_reg[dec_warp]);

    // Only one instruction is ever in the staging slot
    assign stage_fire = stage_valid && data_ready && out_in_ready;
    assign dec_ready  = stage_in_ready && (state == IDLE) && (!stage_valid || stage_fire);
    assign dec_fire   = dec_valid && dec_ready;

    for (genvar t = 0; t < `SIMT_THREADS; t++) begin : g_bank
        logic [`SIMT_XLEN-1:0] mem [`SIMT_WARPS*`SIMT_NREGS];

        always_ff @(posedge clk) begin
            if (wb_valid && wb_tmask[t]) begin
                mem[{wb_warp, wb_rd}] <= wb_data[t];
            end
        end

        assign rd_data[t] = mem[{rd_warp, rd_rid}];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            data_ready <= 1'b0;
        end else begin
            if (stage_fire) begin
                data_ready <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (dec_fire) begin
                        rd_warp  <= dec_warp;
                        rs2_id   <= dec_rs2;
                        rs3_id   <= dec_rs3;
                        rs2_done <= rs2_free;
                        rs3_done <= rs3_free;
                        if (!rs1_free) begin
                            rd_rid <= dec_rs1;
                            state  <= FETCH1;
                        end else if (!rs2_free) begin
                            rd_rid <= dec_rs2;
                            state  <= FETCH2;
                        end else if (!rs3_free) begin
                            rd_rid <= dec_rs3;
                            state  <= FETCH3;
                        end else begin
                            data_ready <= 1'b1;
                        end
                    end
                end
                FETCH1: begin
                    if (!rs2_done) begin
                        rd_rid <= rs2_id;
                        state  <= FETCH2;
                    end else if (!rs3_done) begin
                        rd_rid <= rs3_id;
                        state  <= FETCH3;
                    end else begin
                        data_ready <= 1'b1;
                        state      <= IDLE;
                    end
                end
                FETCH2: begin
                    if (!rs3_done) begin
                        rd_rid <= rs3_id;
                        state  <= FETCH3;
                    end else begin
                        data_ready <= 1'b1;
                        state      <= IDLE;
                    end
                end
                FETCH3: begin
                    data_ready <= 1'b1;
                    state      <= IDLE;
                end
            endcase
        end
    end

    // Free sources load at issue, fetched ones one per cycle after
    always_ff @(posedge clk) begin
        if (dec_fire) begin
            rs1_val <= rs1_zero ? '0 : cache_data[dec_warp];
            rs2_val <= rs2_zero ? '0 : cache_data[dec_warp];
            rs3_val <= rs3_zero ? '0 : cache_data[dec_warp];
        end
        case (state)
            FETCH1:  rs1_val <= rd_data;
            FETCH2:  rs2_val <= rd_data;
            FETCH3:  rs3_val <= rd_data;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cache_valid <= '0;
        end else if (wb_valid) begin
            cache_valid[wb_warp] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            cache_reg[wb_warp]   <= wb_rd;
            cache_tmask[wb_warp] <= wb_tmask;
            cache_data[wb_warp]  <= wb_data;
        end
    end

    skid_buffer #(.payload_t(stage_t)) stage_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dec_fire),
        .in_ready  (stage_in_ready),
        .in_data   ('{op: dec_op, rd: dec_rd, imm: dec_imm, warp: dec_warp, tmask: dec_tmask}),
        .out_valid (stage_valid),
        .out_ready (data_ready && out_in_ready),
        .out_data  (stage_out)
    );

    skid_buffer #(.payload_t(opd_t)) out_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (stage_valid && data_ready),
        .in_ready  (out_in_ready),
        .in_data   ('{ctl: stage_out, rs1: rs1_val, rs2: rs2_val, rs3: rs3_val}),
        .out_valid (opd_valid),
        .out_ready (opd_ready),
        .out_data  (opd_out)
    );

    assign opd_op       = opd_out.ctl.op;
    assign opd_rd       = opd_out.ctl.rd;
    assign opd_imm      = opd_out.ctl.imm;
    assign opd_warp     = opd_out.ctl.warp;
    assign opd_tmask    = opd_out.ctl.tmask;
    assign opd_rs1_data = opd_out.rs1;
    assign opd_rs2_data = opd_out.rs2;
    assign opd_rs3_data = opd_out.rs3;

    // A fetch only runs on a staged entry whose operands are still incomplete
    assert property (@(posedge clk) disable iff (reset)
        state inside {IDLE, FETCH1, FETCH2, FETCH3} &&
        (state == IDLE || (stage_valid && !data_ready)));

endmodule

// ==== hdl/instr_decode.sv ====
/* Instruction decode stage
   Splits the word into fields and holds them in one output register */
`timescale 1ns/10ps
`include "simt_defs.svh"

module instr_decode (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instr_valid,
    output logic                       instr_ready,
    input  logic [31:0]                instr,
    input  logic [`SIMT_WARP_BITS-1:0] instr_warp,
    input  logic [`SIMT_THREADS-1:0]   instr_tmask,
    output logic                       dec_valid,
    input  logic                       dec_ready,
    output simt_pkg::alu_op_e          dec_op,
    output logic [`SIMT_REG_BITS-1:0]  dec_rd,
    output logic [`SIMT_REG_BITS-1:0]  dec_rs1,
    output logic [`SIMT_REG_BITS-1:0]  dec_rs2,
    output logic [`SIMT_REG_BITS-1:0]  dec_rs3,
    output logic [`SIMT_IMM_BITS-1:0]  dec_imm,
    output logic [`SIMT_WARP_BITS-1:0] dec_warp,
    output logic [`SIMT_THREADS-1:0]   dec_tmask
);
    logic [3:0]        op_raw;
    simt_pkg::alu_op_e op;
    logic              is_li;

    assign op_raw = instr[`SIMT_OP_MSB:`SIMT_OP_LSB];
    // Unknown codes fall back to ADD
    assign op     = (op_raw <= 4'(simt_pkg::LI)) ? simt_pkg::alu_op_e'(op_raw) : simt_pkg::ADD;
    assign is_li  = (op == simt_pkg::LI);

    assign instr_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (instr_ready) begin
            dec_valid <= instr_valid;
        end
    end

    // LI reads nothing, so its sources point at register 0
    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready) begin
            dec_op    <= op;
            dec_rd    <= instr[`SIMT_RD_MSB:`SIMT_RD_LSB];
            dec_rs1   <= is_li ? '0 : instr[`SIMT_RS1_MSB:`SIMT_RS1_LSB];
            dec_rs2   <= is_li ? '0 : instr[`SIMT_RS2_MSB:`SIMT_RS2_LSB];
            dec_rs3   <= is_li ? '0 : instr[`SIMT_RS3_MSB:`SIMT_RS3_LSB];
            dec_imm   <= instr[`SIMT_IMM_MSB:`SIMT_IMM_LSB];
            dec_warp  <= instr_warp;
            dec_tmask <= instr_tmask;
        end
    end

    assert property (@(posedge clk) disable iff (reset) dec_valid |-> dec_tmask != '0);

endmodule

// ==== hdl/skid_buffer.sv ====
/* Two-entry valid/ready buffer
   The input side ready is registered and never looks at out_ready */
`timescale 1ns/10ps

module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    payload_t main_data;
    payload_t skid_data;
    logic     main_valid;
    logic     skid_valid;
    logic     main_free;

    assign main_free = !main_valid || out_ready;
    assign in_ready  = !skid_valid;
    assign out_valid = main_valid;
    assign out_data  = main_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            main_valid <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    // A parked entry always drains into the main slot first
    always_ff @(posedge clk) begin
        if (main_free) begin
            main_data <= skid_valid ? skid_data : in_data;
        end else if (in_valid && in_ready) begin
            skid_data <= in_data;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// ==== hdl/simt_pkg.sv ====
/* SIMT core types
   ALU opcodes and the packed per-thread data vector */
`include "simt_defs.svh"

package simt_pkg;

    // Codes are contiguous from zero so the decoder can range-check them
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        MAD = 4'd5,
        LI  = 4'd6
    } alu_op_e;

    typedef logic [`SIMT_THREADS-1:0][`SIMT_XLEN-1:0] thread_data_t;

endpackage

// ==== hdl/simt_defs.svh ====
/* SIMT core sizing and instruction field layout */
`ifndef SIMT_DEFS_SVH
`define SIMT_DEFS_SVH

`define SIMT_XLEN       32
`define SIMT_THREADS    4
`define SIMT_WARPS      2
`define SIMT_NREGS      32
`define SIMT_REG_BITS   5
`define SIMT_WARP_BITS  1

`define SIMT_OP_MSB     3
`define SIMT_OP_LSB     0
`define SIMT_RD_MSB     8
`define SIMT_RD_LSB     4
`define SIMT_RS1_MSB    13
`define SIMT_RS1_LSB    9
`define SIMT_RS2_MSB    18
`define SIMT_RS2_LSB    14
`define SIMT_RS3_MSB    23
`define SIMT_RS3_LSB    19
`define SIMT_IMM_MSB    31
`define SIMT_IMM_LSB    24
`define SIMT_IMM_BITS   8

`endif
